// File: list.f
+incdir+tb
src/lc_pkg.sv
src/des_round.sv
src/des_pipeline.sv
src/message_counter.sv
src/run_control.sv
src/bias_tally.sv
src/lc_block.sv
tb/tb_lc_block.sv

// File: src/bias_tally.sv
`timescale 1ns/1ns
`default_nettype none

// counts pairs where input parity != output parity
module bias_tally
    import lc_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire         restart,
    input  wire         msg_valid,
    input  wire block_t msg,
    input  wire block_t mask_in,
    input  wire         ct_valid,
    input  wire block_t ct,
    input  wire block_t mask_out,
    output count_t      count
);

    logic                  in_par;   // parity of masked plaintext
    logic                  out_par;  // parity of masked ciphertext
    logic [PIPE_DEPTH-1:0] par_dly;  // bit 0 newest
    logic                  mismatch;

    assign in_par  = msg_valid & (^(msg & mask_in));
    assign out_par = ^(ct & mask_out);

    // same latency as the cipher, shifts every cycle like the pipeline
    always_ff @(posedge clk) begin
        par_dly <= {par_dly[PIPE_DEPTH-2:0], in_par};
    end

    assign mismatch = par_dly[PIPE_DEPTH-1] ^ out_par;  // lines up with ct

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (restart) begin
            count <= '0;
        end else if (ct_valid && mismatch) begin
            count <= count + 1'b1;
        end
    end

    a_count_mono: assert property (@(posedge clk) disable iff (!rst_n)
        !restart |=> (count >= $past(count)));

endmodule

`default_nettype wire

// File: src/des_pipeline.sv
`timescale 1ns/1ns
`default_nettype none

// ip register, 16 round stages, combinational fp on the last stage
module des_pipeline
    import lc_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,
    input  wire              restart,
    input  wire              in_valid,
    input  wire block_t      msg,
    input  wire round_keys_t round_keys,
    output logic             ct_valid,
    output block_t           ct,
    output logic             pipe_busy
);

    block_t ip_msg;  // message after initial permutation
    block_t preout;  // r16 l16
    logic   in_v;    // input register
    half_t  in_l;
    half_t  in_r;

    // stage 0 is the input register, stage g+1 is round g+1
    wire [DES_ROUNDS:0] stage_v;
    wire half_t         stage_l [DES_ROUNDS+1];
    wire half_t         stage_r [DES_ROUNDS+1];

    always_comb begin
        for (int i = 0; i < 64; i++) begin
            ip_msg[63 - i] = msg[64 - IP_TABLE[i]];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_v <= 1'b0;
        end else if (restart) begin
            in_v <= 1'b0;
        end else begin
            in_v <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        in_l <= ip_msg[63:32];
        in_r <= ip_msg[31:0];
    end

    assign stage_v[0] = in_v;
    assign stage_l[0] = in_l;
    assign stage_r[0] = in_r;

    for (genvar g = 0; g < DES_ROUNDS; g++) begin : g_round
        des_round u_round (
            .clk       (clk),
            .rst_n     (rst_n),
            .restart   (restart),
            .in_valid  (stage_v[g]),
            .l_in      (stage_l[g]),
            .r_in      (stage_r[g]),
            .subkey    (round_keys[48*DES_ROUNDS-1 - 48*g -: 48]),  // round 1 at the top
            .out_valid (stage_v[g+1]),
            .l_out     (stage_l[g+1]),
            .r_out     (stage_r[g+1])
        );
    end

    assign preout = {stage_r[DES_ROUNDS], stage_l[DES_ROUNDS]};  // undo last swap

    always_comb begin
        for (int i = 0; i < 64; i++) begin
            ct[63 - i] = preout[64 - FP_TABLE[i]];
        end
    end

    assign ct_valid  = stage_v[DES_ROUNDS];
    assign pipe_busy = |stage_v;  // anything still in flight

    a_ct_busy: assert property (@(posedge clk) disable iff (!rst_n)
        ct_valid |-> pipe_busy);

endmodule

`default_nettype wire

// File: src/des_round.sv
`timescale 1ns/1ns
`default_nettype none

// one feistel round, output registered
module des_round
    import lc_pkg::*;
(
    input  wire          clk,
    input  wire          rst_n,
    input  wire          restart,
    input  wire          in_valid,
    input  wire half_t   l_in,
    input  wire half_t   r_in,
    input  wire subkey_t subkey,
    output logic         out_valid,
    output half_t        l_out,
    output half_t        r_out
);

    subkey_t     expanded;  // e(r)
    subkey_t     mixed;     // e(r) ^ k
    logic [5:0]  chunk;     // six bits into one s-box
    logic [31:0] sbox_out;
    half_t       f_out;

    always_comb begin
        for (int i = 0; i < 48; i++) begin
            expanded[47 - i] = r_in[32 - E_TABLE[i]];
        end
        mixed = expanded ^ subkey;
        chunk = '0;
        for (int s = 0; s < 8; s++) begin
            chunk = mixed[47 - 6*s -: 6];
            sbox_out[31 - 4*s -: 4] = SBOX[s][{chunk[5], chunk[0], chunk[4:1]}];  // row b1b6
        end
        for (int i = 0; i < 32; i++) begin
            f_out[31 - i] = sbox_out[32 - P_TABLE[i]];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (restart) begin
            out_valid <= 1'b0;  // flush
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin  // data moves every cycle
        l_out <= r_in;
        r_out <= l_in ^ f_out;      // swap folded in
    end

    a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(out_valid));

endmodule

`default_nettype wire

// File: src/lc_block.sv
`timescale 1ns/1ns
`default_nettype none

// linear cryptanalysis run: counter -> des -> tally, with run control
module lc_block
    import lc_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,
    input  wire              restart,
    input  wire              start,
    input  wire half_t       region,
    input  wire half_t       limit,
    input  wire block_t      mask_in,     // hold from start to done
    input  wire block_t      mask_out,
    input  wire round_keys_t round_keys,
    output wire count_t      count,
    output wire              done
);

    wire    run_go;
    wire    limit_zero;
    wire    last;
    wire    msg_valid;
    wire    ct_valid;
    wire    pipe_busy;
    block_t msg;
    block_t ct;

    assign limit_zero = (limit == '0);  // counter only sees limit on go

    run_control u_run_control (
        .clk        (clk),
        .rst_n      (rst_n),
        .restart    (restart),
        .start      (start),
        .last       (last),
        .limit_zero (limit_zero),
        .pipe_busy  (pipe_busy),
        .run_go     (run_go),
        .done       (done)
    );

    message_counter u_message_counter (
        .clk       (clk),
        .rst_n     (rst_n),
        .restart   (restart),
        .go        (run_go),
        .region    (region),   // captured here
        .limit     (limit),
        .msg       (msg),
        .msg_valid (msg_valid),
        .last      (last)
    );

    des_pipeline u_des_pipeline (
        .clk        (clk),
        .rst_n      (rst_n),
        .restart    (restart),
        .in_valid   (msg_valid),
        .msg        (msg),
        .round_keys (round_keys),
        .ct_valid   (ct_valid),
        .ct         (ct),
        .pipe_busy  (pipe_busy)
    );

    bias_tally u_bias_tally (
        .clk       (clk),
        .rst_n     (rst_n),
        .restart   (restart),
        .msg_valid (msg_valid),
        .msg       (msg),
        .mask_in   (mask_in),
        .ct_valid  (ct_valid),
        .ct        (ct),
        .mask_out  (mask_out),
        .count     (count)
    );

endmodule

`default_nettype wire

// File: src/lc_pkg.sv
`default_nettype none

package lc_pkg;

    localparam int DES_ROUNDS = 16;
    localparam int PIPE_DEPTH = DES_ROUNDS + 1;  // input reg plus one reg per round

    typedef logic [63:0]              block_t;       // message, ciphertext, mask
    typedef logic [31:0]              half_t;        // feistel half, region, index
    typedef logic [47:0]              subkey_t;      // one round key
    typedef logic [48*DES_ROUNDS-1:0] round_keys_t;  // round 1 sits in the top slot
    typedef logic [63:0]              count_t;       // mismatch tally

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN,      // wait for the cipher to empty
        FINISHED
    } run_state_t;

    // all tables use des bit numbering: bit 1 is the msb of the vector
    localparam int IP_TABLE [64] = '{
        58, 50, 42, 34, 26, 18, 10, 2,
        60, 52, 44, 36, 28, 20, 12, 4,
        62, 54, 46, 38, 30, 22, 14, 6,
        64, 56, 48, 40, 32, 24, 16, 8,
        57, 49, 41, 33, 25, 17, 9,  1,
        59, 51, 43, 35, 27, 19, 11, 3,
        61, 53, 45, 37, 29, 21, 13, 5,
        63, 55, 47, 39, 31, 23, 15, 7
    };

    localparam int FP_TABLE [64] = '{  // inverse of ip
        40, 8, 48, 16, 56, 24, 64, 32,
        39, 7, 47, 15, 55, 23, 63, 31,
        38, 6, 46, 14, 54, 22, 62, 30,
        37, 5, 45, 13, 53, 21, 61, 29,
        36, 4, 44, 12, 52, 20, 60, 28,
        35, 3, 43, 11, 51, 19, 59, 27,
        34, 2, 42, 10, 50, 18, 58, 26,
        33, 1, 41, 9,  49, 17, 57, 25
    };

    localparam int E_TABLE [48] = '{  // 32 -> 48 expansion
        32, 1,  2,  3,  4,  5,
        4,  5,  6,  7,  8,  9,
        8,  9,  10, 11, 12, 13,
        12, 13, 14, 15, 16, 17,
        16, 17, 18, 19, 20, 21,
        20, 21, 22, 23, 24, 25,
        24, 25, 26, 27, 28, 29,
        28, 29, 30, 31, 32, 1
    };

    localparam int P_TABLE [32] = '{
        16, 7,  20, 21, 29, 12, 28, 17,
        1,  15, 23, 26, 5,  18, 31, 10,
        2,  8,  24, 14, 32, 27, 3,  9,
        19, 13, 30, 6,  22, 11, 4,  25
    };

    // row-major, entry = row*16 + col
    localparam logic [3:0] SBOX [8][64] = '{
        '{14, 4, 13, 1, 2, 15, 11, 8, 3, 10, 6, 12, 5, 9, 0, 7,
          0, 15, 7, 4, 14, 2, 13, 1, 10, 6, 12, 11, 9, 5, 3, 8,
          4, 1, 14, 8, 13, 6, 2, 11, 15, 12, 9, 7, 3, 10, 5, 0,
          15, 12, 8, 2, 4, 9, 1, 7, 5, 11, 3, 14, 10, 0, 6, 13},
        '{15, 1, 8, 14, 6, 11, 3, 4, 9, 7, 2, 13, 12, 0, 5, 10,
          3, 13, 4, 7, 15, 2, 8, 14, 12, 0, 1, 10, 6, 9, 11, 5,
          0, 14, 7, 11, 10, 4, 13, 1, 5, 8, 12, 6, 9, 3, 2, 15,
          13, 8, 10, 1, 3, 15, 4, 2, 11, 6, 7, 12, 0, 5, 14, 9},
        '{10, 0, 9, 14, 6, 3, 15, 5, 1, 13, 12, 7, 11, 4, 2, 8,
          13, 7, 0, 9, 3, 4, 6, 10, 2, 8, 5, 14, 12, 11, 15, 1,
          13, 6, 4, 9, 8, 15, 3, 0, 11, 1, 2, 12, 5, 10, 14, 7,
          1, 10, 13, 0, 6, 9, 8, 7, 4, 15, 14, 3, 11, 5, 2, 12},
        '{7, 13, 14, 3, 0, 6, 9, 10, 1, 2, 8, 5, 11, 12, 4, 15,
          13, 8, 11, 5, 6, 15, 0, 3, 4, 7, 2, 12, 1, 10, 14, 9,
          10, 6, 9, 0, 12, 11, 7, 13, 15, 1, 3, 14, 5, 2, 8, 4,
          3, 15, 0, 6, 10, 1, 13, 8, 9, 4, 5, 11, 12, 7, 2, 14},
        '{2, 12, 4, 1, 7, 10, 11, 6, 8, 5, 3, 15, 13, 0, 14, 9,
          14, 11, 2, 12, 4, 7, 13, 1, 5, 0, 15, 10, 3, 9, 8, 6,
          4, 2, 1, 11, 10, 13, 7, 8, 15, 9, 12, 5, 6, 3, 0, 14,
          11, 8, 12, 7, 1, 14, 2, 13, 6, 15, 0, 9, 10, 4, 5, 3},
        '{12, 1, 10, 15, 9, 2, 6, 8, 0, 13, 3, 4, 14, 7, 5, 11,
          10, 15, 4, 2, 7, 12, 9, 5, 6, 1, 13, 14, 0, 11, 3, 8,
          9, 14, 15, 5, 2, 8, 12, 3, 7, 0, 4, 10, 1, 13, 11, 6,
          4, 3, 2, 12, 9, 5, 15, 10, 11, 14, 1, 7, 6, 0, 8, 13},
        '{4, 11, 2, 14, 15, 0, 8, 13, 3, 12, 9, 7, 5, 10, 6, 1,
          13, 0, 11, 7, 4, 9, 1, 10, 14, 3, 5, 12, 2, 15, 8, 6,
          1, 4, 11, 13, 12, 3, 7, 14, 10, 15, 6, 8, 0, 5, 9, 2,
          6, 11, 13, 8, 1, 4, 10, 7, 9, 5, 0, 15, 14, 2, 3, 12},
        '{13, 2, 8, 4, 6, 15, 11, 1, 10, 9, 3, 14, 5, 0, 12, 7,
          1, 15, 13, 8, 10, 3, 7, 4, 12, 5, 6, 11, 0, 14, 9, 2,
          7, 11, 4, 1, 9, 12, 14, 2, 0, 6, 10, 13, 15, 3, 5, 8,
          2, 1, 14, 7, 4, 10, 8, 13, 15, 12, 9, 0, 3, 5, 6, 11}
    };

endpackage

`default_nettype wire

// File: src/message_counter.sv
`timescale 1ns/1ns
`default_nettype none

// plaintext = {region, index}, index runs 0 .. limit-1
module message_counter
    import lc_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire        restart,
    input  wire        go,
    input  wire half_t region,
    input  wire half_t limit,
    output block_t     msg,
    output logic       msg_valid,
    output logic       last
);

    half_t region_q;  // latched on go
    half_t limit_q;
    half_t index;
    logic  active;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active <= 1'b0;
            index  <= '0;
        end else if (restart) begin
            active <= 1'b0;
            index  <= '0;
        end else if (go) begin
            active <= (limit != '0);  // zero limit emits nothing
            index  <= '0;
        end else if (active) begin
            if (last) begin
                active <= 1'b0;
            end else begin
                index <= index + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            region_q <= region;
            limit_q  <= limit;
        end
    end

    assign msg       = {region_q, index};
    assign msg_valid = active;
    assign last      = active && (index == limit_q - 1'b1);  // final message

    a_index_range: assert property (@(posedge clk) disable iff (!rst_n)
        msg_valid |-> (index < limit_q));

endmodule

`default_nettype wire

// File: src/run_control.sv
`timescale 1ns/1ns
`default_nettype none

// idle -> run -> drain -> finished, restart goes back to idle
module run_control
    import lc_pkg::*;
(
    input  wire clk,
    input  wire rst_n,
    input  wire restart,
    input  wire start,
    input  wire last,
    input  wire limit_zero,
    input  wire pipe_busy,
    output logic run_go,
    output logic done
);

    run_state_t state;
    run_state_t state_nxt;

    assign run_go = (state == IDLE) && start;  // start ignored elsewhere

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_nxt = limit_zero ? DRAIN : RUN;  // empty run skips ahead
                end
            end
            RUN: begin
                if (last) begin
                    state_nxt = DRAIN;
                end
            end
            DRAIN: begin
                if (!pipe_busy) begin
                    state_nxt = FINISHED;
                end
            end
            FINISHED: state_nxt = FINISHED;  // held until restart
            default:  state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
            done  <= 1'b0;
        end else if (restart) begin
            state <= IDLE;
            done  <= 1'b0;
        end else begin
            state <= state_nxt;
            done  <= (state == FINISHED);  // one cycle behind, lets the tally settle
        end
    end

    a_done_state: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> (state == FINISHED));

endmodule

`default_nettype wire

// File: tb/lc_model.svh
`ifndef LC_MODEL_SVH
`define LC_MODEL_SVH

// reference model, included inside the testbench module

// des of the all-zero block under the all-zero key
localparam block_t ZERO_KEY_CT = 64'h8CA6_4DE9_C1B1_23A7;

// parity of the selected bits, walked one bit at a time
function automatic bit masked_parity(input block_t value, input block_t mask);
    bit p;
    p = 1'b0;
    for (int i = 0; i < 64; i++) begin
        if (mask[i]) begin
            p = p ^ value[i];
        end
    end
    return p;
endfunction

// with mask_out zero the output parity is always 0,
// so every odd input parity is a mismatch
function automatic count_t expected_input_count(
    input half_t  region_v,
    input half_t  limit_v,
    input block_t mask
);
    count_t n;
    n = '0;
    for (int unsigned k = 0; k < limit_v; k++) begin
        if (masked_parity({region_v, half_t'(k)}, mask)) begin
            n = n + 1;
        end
    end
    return n;
endfunction

// edges from the accepted start to done high
function automatic int expected_latency(input half_t limit_v);
    if (limit_v == 0) begin
        return 2;  // straight to drain, pipeline already empty
    end
    return limit_v + PIPE_DEPTH + 2;  // last message, drain, finished, done reg
endfunction

`endif

// File: tb/tb_lc_block.sv
`timescale 1ns/1ns
`default_nettype none

module tb_lc_block
    import lc_pkg::*;
();

    localparam int DONE_TIMEOUT = 2000;  // longest run is 300 + 19 edges

    logic        clk;
    logic        rst_n;
    logic        restart;
    logic        start;
    half_t       region;
    half_t       limit;
    block_t      mask_in;
    block_t      mask_out;
    round_keys_t round_keys;
    count_t      count;
    wire         done;

    string test_name;
    int    test_errors;
    int    tests_ok;
    int    tests_bad;

    `include "lc_model.svh"

    lc_block u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .restart    (restart),
        .start      (start),
        .region     (region),
        .limit      (limit),
        .mask_in    (mask_in),
        .mask_out   (mask_out),
        .round_keys (round_keys),
        .count      (count),
        .done       (done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    task automatic check(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            $display("test %-16s ok", test_name);
            tests_ok++;
        end else begin
            $display("test %-16s %0d error(s)", test_name, test_errors);
            tests_bad++;
        end
    endtask

    function automatic round_keys_t random_keys();
        round_keys_t k;
        for (int i = 0; i < 24; i++) begin
            k[32*i +: 32] = $urandom;  // 24 words fill 768 bits
        end
        return k;
    endfunction

    task automatic load_inputs(input round_keys_t keys, input half_t region_v,
                               input half_t limit_v, input block_t m_in,
                               input block_t m_out);
        @(posedge clk);
        round_keys <= keys;
        region     <= region_v;
        limit      <= limit_v;
        mask_in    <= m_in;
        mask_out   <= m_out;
    endtask

    // returns on the edge that samples start high
    task automatic start_run();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic pulse_restart();
        @(posedge clk);
        restart <= 1'b1;
        @(posedge clk);
        restart <= 1'b0;
    endtask

    // counts edges after the current one until done reads high
    task automatic wait_for_done(output int cycles);
        bit seen;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < DONE_TIMEOUT) begin
            @(negedge clk);  // sample away from the driving edge
            if (done) begin
                seen = 1'b1;
            end else begin
                cycles++;
            end
        end
        if (!seen) begin
            $display("test %s: done never rose within %0d cycles", test_name, DONE_TIMEOUT);
            test_errors++;
        end
    endtask

    // one random run with mask_out zero, optionally poking start mid-run
    task automatic tally_case(input bit poke_start);
        round_keys_t keys;
        half_t       region_v;
        half_t       limit_v;
        block_t      m_in;
        int          delay;
        int          cycles;
        int          expected_cycles;
        keys     = random_keys();
        region_v = $urandom;
        limit_v  = $urandom_range(300, 1);
        m_in     = {$urandom, $urandom};
        delay    = $urandom_range(limit_v + 14, 0);  // second start lands in run or drain
        load_inputs(keys, region_v, limit_v, m_in, '0);
        start_run();
        expected_cycles = expected_latency(limit_v);
        if (poke_start) begin
            repeat (delay) @(posedge clk);
            start_run();                                   // fsm busy so this one is ignored
            expected_cycles = expected_cycles - delay - 2;  // counted from the second start
        end
        wait_for_done(cycles);
        check("count", expected_input_count(region_v, limit_v, m_in), count);
        check("latency", expected_cycles, cycles);
    endtask

    initial begin
        int     cycles;
        int     j;
        int     d;
        half_t  lim;
        bit     dropped;
        bit     rose;
        count_t stray;
        void'($urandom(8));
        tests_ok    = 0;
        tests_bad   = 0;
        rst_n       = 1'b0;
        restart     = 1'b0;
        start       = 1'b0;
        region      = '0;
        limit       = '0;
        mask_in     = '0;
        mask_out    = '0;
        round_keys  = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        begin_test("reset");
        @(negedge clk);
        check("done", 0, done);
        check("count", 0, count);
        end_test();

        begin_test("known_answer");  // zero key, zero plaintext, one ct bit per run
        repeat (8) begin
            j = $urandom_range(63, 0);
            load_inputs('0, '0, 32'd1, '0, block_t'(1) << j);
            start_run();
            wait_for_done(cycles);
            check($sformatf("ct bit %0d", j), ZERO_KEY_CT[j], count);
            check("latency", expected_latency(1), cycles);
            pulse_restart();
        end
        end_test();

        begin_test("input_mask");
        repeat (4) begin
            tally_case(1'b0);
            pulse_restart();
        end
        end_test();

        begin_test("zero_limit");
        load_inputs(random_keys(), $urandom, '0, {$urandom, $urandom}, {$urandom, $urandom});
        start_run();
        wait_for_done(cycles);
        check("count", 0, count);
        check("latency", expected_latency(0), cycles);
        pulse_restart();
        end_test();

        begin_test("restart_mid_run");
        lim = $urandom_range(300, 1);
        d   = $urandom_range(lim + 16, PIPE_DEPTH);  // tally already counting, done not yet up
        load_inputs(random_keys(), $urandom, lim, {$urandom, $urandom}, '0);
        start_run();
        repeat (d) @(posedge clk);
        pulse_restart();
        rose  = 1'b0;
        stray = '0;
        repeat (PIPE_DEPTH + 4) begin  // a stale ct left in the pipe would bump count here
            @(negedge clk);
            rose  = rose | done;
            stray = stray | count;
        end
        check("done", 0, rose);
        check("count", 0, stray);
        tally_case(1'b0);  // fresh run after the flush
        pulse_restart();
        end_test();

        begin_test("start_in_run");
        repeat (2) begin
            tally_case(1'b1);
            dropped = 1'b0;
            repeat ($urandom_range(20, 5)) begin
                @(negedge clk);
                if (!done) begin
                    dropped = 1'b1;
                end
            end
            check("done dropped", 0, dropped);  // must hold until restart
            pulse_restart();
            @(negedge clk);
            check("done after restart", 0, done);
        end
        end_test();

        $display("tests ok: %0d, tests with errors: %0d", tests_ok, tests_bad);
        if (tests_bad == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
